// ==== hdl/cnn_quad_pkg.sv ====
package cnn_quad_pkg;

    ////////////////////////////////////////
    // Data widths
    ////////////////////////////////////////
    localparam int PIXEL_WIDTH  = 8;
    localparam int WEIGHT_WIDTH = 8;
    // Holds the sum of 8 full-scale products plus a sign bit
    localparam int ACC_WIDTH    = 20;
    localparam int RESULT_WIDTH = 16;

    ////////////////////////////////////////
    // Storage sizes
    ////////////////////////////////////////
    localparam int MAX_COLS     = 64;
    localparam int MAX_TAPS     = 8;
    localparam int MAX_KERNELS  = 4;
    // One fixed slot of MAX_TAPS entries per kernel
    localparam int WEIGHT_DEPTH = MAX_KERNELS * MAX_TAPS;

    typedef logic signed [PIXEL_WIDTH-1:0]  pixel_t;
    typedef logic signed [WEIGHT_WIDTH-1:0] weight_t;
    typedef logic signed [ACC_WIDTH-1:0]    acc_t;
    typedef logic signed [RESULT_WIDTH-1:0] result_t;

    // Counts must reach their maximum, so one extra value
    typedef logic [$clog2(MAX_COLS+1)-1:0]    col_t;
    typedef logic [$clog2(MAX_TAPS+1)-1:0]    tap_t;
    typedef logic [$clog2(MAX_KERNELS+1)-1:0] depth_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD_WEIGHTS,
        ST_LOAD_PIXELS,
        ST_COMPUTE,
        ST_DONE
    } quad_state_e;

    typedef enum logic {
        ACT_NONE,
        ACT_RELU
    } activation_e;

endpackage

// ==== hdl/quad_job_ctrl.sv ====
module quad_job_ctrl (
    input  logic                      clk_core,
    input  logic                      rst,
    input  logic                      job_valid,
    input  cnn_quad_pkg::col_t        job_cols,
    input  cnn_quad_pkg::tap_t        job_taps,
    input  cnn_quad_pkg::depth_t      job_kernels,
    input  cnn_quad_pkg::activation_e job_activation,
    input  logic                      weights_loaded,
    input  logic                      pixels_loaded,
    input  logic                      scan_done,
    input  logic                      engine_idle,
    output logic                      job_ready,
    output logic                      weight_ready,
    output logic                      pixel_ready,
    output logic                      compute_start,
    output logic                      job_done,
    output cnn_quad_pkg::col_t        cfg_cols,
    output cnn_quad_pkg::tap_t        cfg_taps,
    output cnn_quad_pkg::depth_t      cfg_kernels,
    output cnn_quad_pkg::activation_e cfg_activation
);
    import cnn_quad_pkg::*;

    quad_state_e state;

    // Loaded flags close the streams in the cycle they rise
    assign job_ready     = (state == ST_IDLE);
    assign weight_ready  = (state == ST_LOAD_WEIGHTS) && !weights_loaded;
    assign pixel_ready   = (state == ST_LOAD_PIXELS) && !pixels_loaded;
    assign compute_start = (state == ST_LOAD_PIXELS) && pixels_loaded;
    assign job_done      = (state == ST_DONE);

    always_ff @(posedge clk_core) begin
        if (rst) begin
            state          <= ST_IDLE;
            cfg_cols       <= '0;
            cfg_taps       <= '0;
            cfg_kernels    <= '0;
            cfg_activation <= ACT_NONE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (job_valid) begin
                        cfg_cols       <= job_cols;
                        cfg_taps       <= job_taps;
                        cfg_kernels    <= job_kernels;
                        cfg_activation <= job_activation;
                        state          <= ST_LOAD_WEIGHTS;
                    end
                end
                ST_LOAD_WEIGHTS: begin
                    if (weights_loaded) begin
                        state <= ST_LOAD_PIXELS;
                    end
                end
                ST_LOAD_PIXELS: begin
                    if (pixels_loaded) begin
                        state <= ST_COMPUTE;
                    end
                end
                ST_COMPUTE: begin
                    // Last position issued and pipeline drained
                    if (scan_done && engine_idle) begin
                        state <= ST_DONE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== hdl/conv_position_counter.sv ====
module conv_position_counter (
    input  logic                 clk_core,
    input  logic                 rst,
    input  logic                 compute_start,
    input  logic                 advance,
    input  cnn_quad_pkg::col_t   cfg_cols,
    input  cnn_quad_pkg::tap_t   cfg_taps,
    input  cnn_quad_pkg::depth_t cfg_kernels,
    output logic                 issue_valid,
    output cnn_quad_pkg::col_t   rd_col,
    output cnn_quad_pkg::tap_t   rd_tap,
    output cnn_quad_pkg::depth_t rd_depth,
    output logic                 last_tap,
    output logic                 scan_done
);
    import cnn_quad_pkg::*;

    logic active;
    logic last_col;
    logic last_depth;

    assign issue_valid = active;
    assign last_tap    = active && (rd_tap == cfg_taps - tap_t'(1));
    // Stride 1, so the final column is cols minus taps
    assign last_col    = (rd_col == cfg_cols - col_t'(cfg_taps));
    assign last_depth  = (rd_depth == cfg_kernels - depth_t'(1));

    always_ff @(posedge clk_core) begin
        if (rst || compute_start) begin
            active    <= compute_start;
            scan_done <= 1'b0;
            rd_col    <= '0;
            rd_tap    <= '0;
            rd_depth  <= '0;
        end else if (active && advance) begin
            // Tap fastest, then column, then kernel
            if (last_tap) begin
                rd_tap <= '0;
                if (last_col) begin
                    rd_col <= '0;
                    if (last_depth) begin
                        active    <= 1'b0;
                        scan_done <= 1'b1;
                    end else begin
                        rd_depth <= rd_depth + depth_t'(1);
                    end
                end else begin
                    rd_col <= rd_col + col_t'(1);
                end
            end else begin
                rd_tap <= rd_tap + tap_t'(1);
            end
        end
    end

endmodule

// ==== hdl/pixel_prefetch_buffer.sv ====
module pixel_prefetch_buffer (
    input  logic               clk_core,
    input  logic               rst,
    input  logic               pixel_valid,
    input  logic               pixel_ready,
    input  cnn_quad_pkg::pixel_t pixel_data,
    input  cnn_quad_pkg::col_t cfg_cols,
    input  logic               compute_start,
    input  cnn_quad_pkg::col_t rd_col,
    input  cnn_quad_pkg::tap_t rd_tap,
    input  logic               advance,
    output logic               pixels_loaded,
    output cnn_quad_pkg::pixel_t pixel_out
);
    import cnn_quad_pkg::*;

    pixel_t row_mem [MAX_COLS];
    col_t   wr_ptr;
    col_t   rd_sum;
    logic   wr_en;

    assign wr_en         = pixel_valid && pixel_ready;
    assign pixels_loaded = (wr_ptr == cfg_cols);
    // Input column for this output column and tap
    assign rd_sum        = rd_col + col_t'(rd_tap);

    ////////////////////////////////////////
    // Write side
    ////////////////////////////////////////
    always_ff @(posedge clk_core) begin
        if (rst || compute_start) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            wr_ptr <= wr_ptr + col_t'(1);
        end
    end

    always_ff @(posedge clk_core) begin
        if (wr_en) begin
            row_mem[wr_ptr[$clog2(MAX_COLS)-1:0]] <= pixel_data;
        end
    end

    ////////////////////////////////////////
    // Read side
    ////////////////////////////////////////
    // Holds with the rest of the pipe under back-pressure
    always_ff @(posedge clk_core) begin
        if (advance) begin
            pixel_out <= row_mem[rd_sum[$clog2(MAX_COLS)-1:0]];
        end
    end

endmodule

// ==== hdl/kernel_weight_table.sv ====
module kernel_weight_table (
    input  logic                  clk_core,
    input  logic                  rst,
    input  logic                  weight_valid,
    input  logic                  weight_ready,
    input  cnn_quad_pkg::weight_t weight_data,
    input  cnn_quad_pkg::tap_t    cfg_taps,
    input  cnn_quad_pkg::depth_t  cfg_kernels,
    input  logic                  compute_start,
    input  cnn_quad_pkg::depth_t  rd_depth,
    input  cnn_quad_pkg::tap_t    rd_tap,
    input  logic                  advance,
    output logic                  weights_loaded,
    output cnn_quad_pkg::weight_t weight_out
);
    import cnn_quad_pkg::*;

    weight_t                         wt_mem [WEIGHT_DEPTH];
    tap_t                            wr_tap;
    depth_t                          wr_depth;
    logic                            wr_en;
    logic [$clog2(WEIGHT_DEPTH)-1:0] wr_addr;
    logic [$clog2(WEIGHT_DEPTH)-1:0] rd_addr;

    assign wr_en          = weight_valid && weight_ready;
    // All kernels written once the kernel index runs past the last one
    assign weights_loaded = (wr_depth == cfg_kernels);

    // Each kernel owns a slot of MAX_TAPS entries
    assign wr_addr = ($clog2(WEIGHT_DEPTH))'(int'(wr_depth) * MAX_TAPS + int'(wr_tap));
    assign rd_addr = ($clog2(WEIGHT_DEPTH))'(int'(rd_depth) * MAX_TAPS + int'(rd_tap));

    always_ff @(posedge clk_core) begin
        if (rst || compute_start) begin
            wr_tap   <= '0;
            wr_depth <= '0;
        end else if (wr_en) begin
            if (wr_tap == cfg_taps - tap_t'(1)) begin
                wr_tap   <= '0;
                wr_depth <= wr_depth + depth_t'(1);
            end else begin
                wr_tap <= wr_tap + tap_t'(1);
            end
        end
    end

    always_ff @(posedge clk_core) begin
        if (wr_en) begin
            wt_mem[wr_addr] <= weight_data;
        end
        if (advance) begin
            weight_out <= wt_mem[rd_addr];
        end
    end

endmodule

// ==== hdl/mac_activation_engine.sv ====
module mac_activation_engine (
    input  logic                      clk_core,
    input  logic                      rst,
    input  logic                      issue_valid,
    input  logic                      last_tap,
    input  cnn_quad_pkg::activation_e cfg_activation,
    input  cnn_quad_pkg::pixel_t      pixel_out,
    input  cnn_quad_pkg::weight_t     weight_out,
    input  logic                      result_ready,
    output logic                      advance,
    output logic                      engine_idle,
    output logic                      result_valid,
    output cnn_quad_pkg::result_t     result_data
);
    import cnn_quad_pkg::*;

    logic rd_valid;
    logic rd_last;
    acc_t acc;
    acc_t product;
    acc_t acc_sum;

    // Clamp to the signed 16-bit range
    function automatic result_t saturate(acc_t value);
        if (&value[ACC_WIDTH-1:RESULT_WIDTH-1] || ~|value[ACC_WIDTH-1:RESULT_WIDTH-1]) begin
            return value[RESULT_WIDTH-1:0];
        end else if (value[ACC_WIDTH-1]) begin
            return {1'b1, {(RESULT_WIDTH-1){1'b0}}};
        end
        return {1'b0, {(RESULT_WIDTH-1){1'b1}}};
    endfunction

    function automatic result_t activate(result_t value, activation_e act);
        if (act == ACT_RELU && value[RESULT_WIDTH-1]) begin
            return '0;
        end
        return value;
    endfunction

    // Stall only while a held result is refused
    assign advance     = !(result_valid && !result_ready);
    assign engine_idle = !rd_valid && !result_valid;
    assign product     = acc_t'(pixel_out) * acc_t'(weight_out);
    assign acc_sum     = acc + product;

    ////////////////////////////////////////
    // Accumulate and output register
    ////////////////////////////////////////
    always_ff @(posedge clk_core) begin
        if (rst) begin
            rd_valid     <= 1'b0;
            rd_last      <= 1'b0;
            acc          <= '0;
            result_valid <= 1'b0;
        end else begin
            if (result_valid && result_ready) begin
                result_valid <= 1'b0;
            end
            if (advance) begin
                // Line up with the one-cycle memory read
                rd_valid <= issue_valid;
                rd_last  <= last_tap;
                if (rd_valid) begin
                    if (rd_last) begin
                        acc          <= '0;
                        result_valid <= 1'b1;
                    end else begin
                        acc <= acc_sum;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_core) begin
        if (advance && rd_valid && rd_last) begin
            result_data <= activate(saturate(acc_sum), cfg_activation);
        end
    end

endmodule

// ==== hdl/cnn_quad.sv ====
module cnn_quad (
    input  logic                      clk_core,
    input  logic                      rst,
    input  logic                      job_valid,
    input  cnn_quad_pkg::col_t        job_cols,
    input  cnn_quad_pkg::tap_t        job_taps,
    input  cnn_quad_pkg::depth_t      job_kernels,
    input  cnn_quad_pkg::activation_e job_activation,
    input  logic                      weight_valid,
    input  cnn_quad_pkg::weight_t     weight_data,
    input  logic                      pixel_valid,
    input  cnn_quad_pkg::pixel_t      pixel_data,
    input  logic                      result_ready,
    output logic                      job_ready,
    output logic                      weight_ready,
    output logic                      pixel_ready,
    output logic                      result_valid,
    output cnn_quad_pkg::result_t     result_data,
    output logic                      job_done
);
    import cnn_quad_pkg::*;

    ////////////////////////////////////////
    // Internal wires
    ////////////////////////////////////////
    col_t        cfg_cols;
    tap_t        cfg_taps;
    depth_t      cfg_kernels;
    activation_e cfg_activation;
    logic        compute_start;
    logic        weights_loaded;
    logic        pixels_loaded;
    logic        scan_done;
    logic        engine_idle;
    logic        issue_valid;
    logic        last_tap;
    logic        advance;
    col_t        rd_col;
    tap_t        rd_tap;
    depth_t      rd_depth;
    pixel_t      pixel_out;
    weight_t     weight_out;

    quad_job_ctrl i_quad_job_ctrl (
        .clk_core       (clk_core),
        .rst            (rst),
        .job_valid      (job_valid),
        .job_cols       (job_cols),
        .job_taps       (job_taps),
        .job_kernels    (job_kernels),
        .job_activation (job_activation),
        .weights_loaded (weights_loaded),
        .pixels_loaded  (pixels_loaded),
        .scan_done      (scan_done),
        .engine_idle    (engine_idle),
        .job_ready      (job_ready),
        .weight_ready   (weight_ready),
        .pixel_ready    (pixel_ready),
        .compute_start  (compute_start),
        .job_done       (job_done),
        .cfg_cols       (cfg_cols),
        .cfg_taps       (cfg_taps),
        .cfg_kernels    (cfg_kernels),
        .cfg_activation (cfg_activation)
    );

    conv_position_counter i_conv_position_counter (
        .clk_core      (clk_core),
        .rst           (rst),
        .compute_start (compute_start),
        .advance       (advance),
        .cfg_cols      (cfg_cols),
        .cfg_taps      (cfg_taps),
        .cfg_kernels   (cfg_kernels),
        .issue_valid   (issue_valid),
        .rd_col        (rd_col),
        .rd_tap        (rd_tap),
        .rd_depth      (rd_depth),
        .last_tap      (last_tap),
        .scan_done     (scan_done)
    );

    pixel_prefetch_buffer i_pixel_prefetch_buffer (
        .clk_core      (clk_core),
        .rst           (rst),
        .pixel_valid   (pixel_valid),
        .pixel_ready   (pixel_ready),
        .pixel_data    (pixel_data),
        .cfg_cols      (cfg_cols),
        .compute_start (compute_start),
        .rd_col        (rd_col),
        .rd_tap        (rd_tap),
        .advance       (advance),
        .pixels_loaded (pixels_loaded),
        .pixel_out     (pixel_out)
    );

    kernel_weight_table i_kernel_weight_table (
        .clk_core       (clk_core),
        .rst            (rst),
        .weight_valid   (weight_valid),
        .weight_ready   (weight_ready),
        .weight_data    (weight_data),
        .cfg_taps       (cfg_taps),
        .cfg_kernels    (cfg_kernels),
        .compute_start  (compute_start),
        .rd_depth       (rd_depth),
        .rd_tap         (rd_tap),
        .advance        (advance),
        .weights_loaded (weights_loaded),
        .weight_out     (weight_out)
    );

    mac_activation_engine i_mac_activation_engine (
        .clk_core       (clk_core),
        .rst            (rst),
        .issue_valid    (issue_valid),
        .last_tap       (last_tap),
        .cfg_activation (cfg_activation),
        .pixel_out      (pixel_out),
        .weight_out     (weight_out),
        .result_ready   (result_ready),
        .advance        (advance),
        .engine_idle    (engine_idle),
        .result_valid   (result_valid),
        .result_data    (result_data)
    );

endmodule

// ==== verification/tb_cnn_quad.sv ====
module tb_cnn_quad;
    import cnn_quad_pkg::*;

    localparam int CLK_PERIOD     = 100;
    localparam int RESET_CYCLES   = 10;
    localparam int HANDSHAKE_WAIT = 200;
    localparam int JOB_WAIT       = 5000;

    logic        clk_core;
    logic        rst;
    logic        job_valid;
    col_t        job_cols;
    tap_t        job_taps;
    depth_t      job_kernels;
    activation_e job_activation;
    logic        weight_valid;
    weight_t     weight_data;
    logic        pixel_valid;
    pixel_t      pixel_data;
    logic        result_ready;
    logic        job_ready;
    logic        weight_ready;
    logic        pixel_ready;
    logic        result_valid;
    result_t     result_data;
    logic        job_done;

    int          golden_fd;
    int          error_count;
    int          check_count;
    int          result_count;
    logic [31:0] rand_state;
    logic        halted;

    // Current job as read from the golden file
    int          cfg_cols;
    int          cfg_taps;
    int          cfg_kernels;
    int          cfg_act;
    int          weight_q[$];
    int          pixel_q[$];
    int          expect_q[$];

    initial clk_core = 1'b0;
    always #(CLK_PERIOD / 2) clk_core = ~clk_core;

    cnn_quad i_cnn_quad (
        .clk_core       (clk_core),
        .rst            (rst),
        .job_valid      (job_valid),
        .job_cols       (job_cols),
        .job_taps       (job_taps),
        .job_kernels    (job_kernels),
        .job_activation (job_activation),
        .weight_valid   (weight_valid),
        .weight_data    (weight_data),
        .pixel_valid    (pixel_valid),
        .pixel_data     (pixel_data),
        .result_ready   (result_ready),
        .job_ready      (job_ready),
        .weight_ready   (weight_ready),
        .pixel_ready    (pixel_ready),
        .result_valid   (result_valid),
        .result_data    (result_data),
        .job_done       (job_done)
    );

    ////////////////////////////////////////
    // Checks and run control
    ////////////////////////////////////////
    function automatic logic [31:0] lcg_next(logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Stops the job sequence after a failure that it cannot recover from
    task automatic halt_run(string why);
        error_count++;
        $display("%s", why);
        halted = 1'b1;
    endtask

    task automatic compare_result(string name, result_t expected, result_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Error %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    task automatic compare_count(string name, col_t expected, col_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Error %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    task automatic compare_flag(string name, logic expected, logic actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Error %s expected %0b actual %0b", name, expected, actual);
        end
    endtask

    ////////////////////////////////////////
    // Golden file reading
    ////////////////////////////////////////
    task automatic skip_line();
        int c;
        c = $fgetc(golden_fd);
        while (c != 10 && c != -1) begin
            c = $fgetc(golden_fd);
        end
    endtask

    task automatic read_value(output int value);
        int code;
        value = 0;
        code  = $fscanf(golden_fd, "%d", value);
        if (code != 1 && !halted) begin
            halt_run("The golden file ended early or holds a value that is not a number");
        end
    endtask

    task automatic load_job();
        int value;
        weight_q.delete();
        pixel_q.delete();
        expect_q.delete();
        read_value(cfg_cols);
        read_value(cfg_taps);
        read_value(cfg_kernels);
        read_value(cfg_act);
        repeat (cfg_kernels * cfg_taps) begin
            read_value(value);
            weight_q.push_back(value);
        end
        repeat (cfg_cols) begin
            read_value(value);
            pixel_q.push_back(value);
        end
        repeat ((cfg_cols - cfg_taps + 1) * cfg_kernels) begin
            read_value(value);
            expect_q.push_back(value);
        end
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////
    task automatic send_job();
        int   cyc;
        logic accepted;
        job_valid      <= 1'b1;
        job_cols       <= col_t'(cfg_cols);
        job_taps       <= tap_t'(cfg_taps);
        job_kernels    <= depth_t'(cfg_kernels);
        job_activation <= (cfg_act != 0) ? ACT_RELU : ACT_NONE;
        cyc      = 0;
        accepted = 1'b0;
        while (!accepted && cyc < HANDSHAKE_WAIT) begin
            @(posedge clk_core);
            cyc++;
            accepted = job_ready;
        end
        job_valid <= 1'b0;
        if (!accepted) begin
            halt_run("Timed out waiting for job_ready to accept a job");
        end
    endtask

    task automatic send_weights();
        int   cyc;
        logic accepted;
        for (int i = 0; i < weight_q.size() && !halted; i++) begin
            weight_valid <= 1'b1;
            weight_data  <= weight_t'(weight_q[i]);
            cyc      = 0;
            accepted = 1'b0;
            while (!accepted && cyc < HANDSHAKE_WAIT) begin
                @(posedge clk_core);
                cyc++;
                accepted = weight_ready;
            end
            if (!accepted) begin
                halt_run("Timed out waiting for weight_ready to accept a weight");
            end
        end
        weight_valid <= 1'b0;
    endtask

    task automatic send_pixels();
        int   cyc;
        logic accepted;
        for (int i = 0; i < pixel_q.size() && !halted; i++) begin
            pixel_valid <= 1'b1;
            pixel_data  <= pixel_t'(pixel_q[i]);
            cyc      = 0;
            accepted = 1'b0;
            while (!accepted && cyc < HANDSHAKE_WAIT) begin
                @(posedge clk_core);
                cyc++;
                accepted = pixel_ready;
            end
            if (!accepted) begin
                halt_run("Timed out waiting for pixel_ready to accept a pixel");
            end
        end
        pixel_valid <= 1'b0;
    endtask

    ////////////////////////////////////////
    // Result collection with random back-pressure
    ////////////////////////////////////////
    task automatic collect_results(int job_index);
        int      out_cols;
        int      total;
        int      n;
        int      cyc;
        int      kidx;
        logic    done_seen;
        logic    held_valid;
        result_t held_data;
        col_t    per_kernel [MAX_KERNELS];
        out_cols   = cfg_cols - cfg_taps + 1;
        total      = out_cols * cfg_kernels;
        n          = 0;
        cyc        = 0;
        done_seen  = 1'b0;
        held_valid = 1'b0;
        held_data  = '0;
        foreach (per_kernel[k]) begin
            per_kernel[k] = '0;
        end
        while (!done_seen && !halted && cyc < JOB_WAIT) begin
            @(posedge clk_core);
            cyc++;
            // A refused result must stay unchanged
            if (held_valid) begin
                compare_flag($sformatf("job %0d result_valid hold", job_index),
                             1'b1, result_valid);
                compare_result($sformatf("job %0d result_data hold", job_index),
                               held_data, result_data);
            end
            if (result_valid && result_ready) begin
                if (n < total) begin
                    compare_result($sformatf("job %0d result %0d", job_index, n),
                                   result_t'(expect_q[n]), result_data);
                end else begin
                    error_count++;
                    $display("Job %0d delivered more than %0d results", job_index, total);
                end
                kidx = n / out_cols;
                if (kidx >= cfg_kernels) begin
                    kidx = cfg_kernels - 1;
                end
                per_kernel[kidx] = per_kernel[kidx] + col_t'(1);
                n++;
                result_count++;
            end
            held_valid   = result_valid && !result_ready;
            held_data    = result_data;
            done_seen    = job_done;
            rand_state   = lcg_next(rand_state);
            result_ready <= (rand_state[31:29] > 3'd1);
        end
        if (!done_seen) begin
            if (!halted) begin
                halt_run($sformatf("Timed out waiting for job_done of job %0d", job_index));
            end
        end else begin
            for (int k = 0; k < cfg_kernels; k++) begin
                compare_count($sformatf("job %0d kernel %0d result count", job_index, k),
                              col_t'(out_cols), per_kernel[k]);
            end
            @(posedge clk_core);
            compare_flag($sformatf("job %0d job_done single pulse", job_index), 1'b0, job_done);
            compare_flag($sformatf("job %0d job_ready after done", job_index), 1'b1, job_ready);
            compare_flag($sformatf("job %0d no result after done", job_index),
                         1'b0, result_valid);
        end
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////
    initial begin
        int job_count;
        int job;
        error_count    = 0;
        check_count    = 0;
        result_count   = 0;
        job_count      = 0;
        halted         = 1'b0;
        rand_state     = 32'hf155919a;
        rst            <= 1'b1;
        job_valid      <= 1'b0;
        job_cols       <= '0;
        job_taps       <= '0;
        job_kernels    <= '0;
        job_activation <= ACT_NONE;
        weight_valid   <= 1'b0;
        weight_data    <= '0;
        pixel_valid    <= 1'b0;
        pixel_data     <= '0;
        result_ready   <= 1'b0;

        golden_fd = $fopen("verification/cnn_quad_golden.txt", "r");
        if (golden_fd == 0) begin
            halt_run("Could not open verification/cnn_quad_golden.txt");
        end else begin
            // Two column description lines open the file
            skip_line();
            skip_line();
            read_value(job_count);
        end

        repeat (RESET_CYCLES) @(posedge clk_core);
        rst <= 1'b0;
        @(posedge clk_core);
        compare_flag("reset job_ready", 1'b1, job_ready);
        compare_flag("reset weight_ready", 1'b0, weight_ready);
        compare_flag("reset pixel_ready", 1'b0, pixel_ready);
        compare_flag("reset result_valid", 1'b0, result_valid);
        compare_flag("reset job_done", 1'b0, job_done);

        // Jobs run back to back
        for (job = 0; job < job_count && !halted; job++) begin
            load_job();
            if (!halted) begin
                fork
                    begin
                        send_job();
                        send_weights();
                        send_pixels();
                    end
                    collect_results(job);
                join
            end
        end
        if (golden_fd != 0) begin
            $fclose(golden_fd);
        end

        $display("Jobs %0d, results %0d, checks %0d, errors %0d",
                 job_count, result_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== cnn_quad.f ====
hdl/cnn_quad_pkg.sv
hdl/quad_job_ctrl.sv
hdl/conv_position_counter.sv
hdl/pixel_prefetch_buffer.sv
hdl/kernel_weight_table.sv
hdl/mac_activation_engine.sv
hdl/cnn_quad.sv
verification/tb_cnn_quad.sv

// ==== Makefile ====
# Verilator build and run for the cnn_quad testbench

VERILATOR ?= verilator
TOP       ?= tb_cnn_quad
FILELIST  ?= cnn_quad.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Verification passed

SOURCES   := $(shell cat $(FILELIST))
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/cnn_quad_golden.txt ====
# Job count, then per job: cols taps kernels activation, weights kernel by kernel,
# pixels of the row, expected results column fastest then kernel (activation 1 is ReLU)
4

8 3 1 0
1 -2 3
5 -3 7 0 -8 4 2 -1
32 -17 -17 28 -10 -3

6 2 3 0
1 1
2 -1
-3 4
10 -20 30 -40 50 -60
-10 10 -10 10 -10
40 -70 100 -130 160
-110 180 -250 320 -390

9 8 2 0
127 127 127 127 127 127 127 127
-128 -128 -128 -128 -128 -128 -128 -128
127 127 127 127 127 127 127 127 -128
32767 32767 -32768 -32768

10 8 2 1
127 127 127 127 127 127 127 127
-128 -128 -128 -128 -128 -128 -128 -128
120 100 30 -10 20 15 -5 30 -127 -128
32767 6731 0 0 0 22400
